/* minimac_rx_sub.f */
design/minimac_pkg.sv
design/minimac_wb_if.sv
design/minimac_rxfifo.sv
design/minimac_rx.sv
design/minimac_slots.sv
design/minimac_rxmem.sv
design/minimac_rx_top.sv
verification/tb_minimac_rx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the receive path testbench with Verilator, runs it and scans the log.
LOG=sim.log

rm -rf obj_dir && \
verilator --binary --timing -Wno-fatal --top-module tb_minimac_rx \
	-f minimac_rx_sub.f -o sim_tb > "$LOG" 2>&1 && \
./obj_dir/sim_tb >> "$LOG" 2>&1 || echo "Build or simulation ended with an error status."

grep -q "TEST FAILED" "$LOG" && { echo "Simulation failed, see $LOG."; exit 1; }
grep -q "TEST PASSED" "$LOG" || { echo "No pass result in $LOG."; exit 1; }
echo "Simulation passed."
exit 0

/* verification/tb_minimac_rx.sv */
`timescale 1ns/1ps

module tb_minimac_rx;
	import minimac_pkg::*;

	localparam logic [CNT_W-1:0] TB_MTU = 11'd16;
	// About 130 bytes at 5 sys_clk cycles each plus waits stay below 2000 cycles.
	localparam int TIMEOUT_CYCLES = 20000;

	logic sys_clk;
	logic sys_rst;
	logic rx_rst;
	logic phy_rx_clk;
	logic [3:0] phy_rx_data;
	logic phy_dv;
	logic phy_rx_er;
	logic fifo_full;
	logic slot_wr;
	logic [SLOT_SEL_W-1:0] slot_sel;
	logic [ADR_W-1:0] slot_adr;
	logic [SLOT_COUNT-1:0] slot_done;
	logic [CNT_W-1:0] slot_count;
	logic [MEM_AW-1:0] dbg_adr;
	logic [WORD_W-1:0] dbg_dat;

	logic [7:0] payload [0:129];  // Bytes of all frames, one region per test.
	integer seed;
	int cycle_cnt;

	minimac_rx_top #(
		.MTU(TB_MTU)
	) dut (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.rx_rst_i     (rx_rst),
		.phy_rx_clk_i (phy_rx_clk),
		.phy_rx_data_i(phy_rx_data),
		.phy_dv_i     (phy_dv),
		.phy_rx_er_i  (phy_rx_er),
		.fifo_full_o  (fifo_full),
		.slot_wr_i    (slot_wr),
		.slot_sel_i   (slot_sel),
		.slot_adr_i   (slot_adr),
		.slot_done_o  (slot_done),
		.slot_count_o (slot_count),
		.dbg_adr_i    (dbg_adr),
		.dbg_dat_o    (dbg_dat)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Clocks and timeout
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;  // 40 ns period.
	end

	initial begin
		phy_rx_clk = 1'b0;
		forever #50 phy_rx_clk = ~phy_rx_clk;  // 100 ns period.
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, a frame was never completed.", cycle_cnt);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped by the cycle limit.");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Driver and checker tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_eq(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch.");
		end
	endtask

	task automatic fill_payload(input int off, input int n);
		logic [31:0] rnd;
		for (int i = 0; i < n; i++) begin
			rnd = $random(seed);
			payload[off+i] = rnd[7:0];
		end
	endtask

	task automatic send_frame(input int off, input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge phy_rx_clk);
			phy_dv = 1'b1;
			phy_rx_data = payload[off+i][3:0];  // Low nibble goes first.
			@(negedge phy_rx_clk);
			phy_rx_data = payload[off+i][7:4];
		end
		@(negedge phy_rx_clk);
		phy_dv = 1'b0;  // Falling dv writes the eof entry.
		phy_rx_data = 4'h0;
		repeat (2) @(negedge phy_rx_clk);
	endtask

	task automatic arm_slot(input int sel, input int base);
		@(negedge sys_clk);
		slot_wr = 1'b1;
		slot_sel = sel[SLOT_SEL_W-1:0];
		slot_adr = base[ADR_W-1:0];
		@(negedge sys_clk);
		slot_wr = 1'b0;
	endtask

	task automatic wait_done(input int sel);
		@(negedge sys_clk);
		while (slot_done[sel] !== 1'b1)
			@(negedge sys_clk);
	endtask

	task automatic read_word(input int adr, output logic [31:0] val);
		@(negedge sys_clk);
		dbg_adr = adr[MEM_AW-1:0];
		@(negedge sys_clk);
		val = dbg_dat;  // Debug port reads combinationally.
	endtask

	task automatic check_count(input int sel, input int n);
		@(negedge sys_clk);
		slot_sel = sel[SLOT_SEL_W-1:0];
		@(negedge sys_clk);
		check_eq($sformatf("slot_count_o[%0d]", sel), 32'(slot_count), n);
	endtask

	// Only the bytes below the MTU land in memory, packed big-endian.
	task automatic check_stored(input int base, input int off, input int n);
		int stored;
		int k;
		logic [31:0] exp_word;
		logic [31:0] mask;
		logic [31:0] got;
		stored = (n > int'(TB_MTU)) ? int'(TB_MTU) : n;
		for (int w = 0; w < (stored + 3) / 4; w++) begin
			k = (stored - 4 * w > 4) ? 4 : stored - 4 * w;
			exp_word = {payload[off+4*w], payload[off+4*w+1],
				payload[off+4*w+2], payload[off+4*w+3]};
			mask = 32'hffff_ffff << (8 * (4 - k));  // Tail bytes of a last word are free.
			read_word(base + w, got);
			check_eq($sformatf("dbg_dat_o[%0d]", base + w), got & mask, exp_word & mask);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic single_frame_store();
		fill_payload(0, 12);
		arm_slot(0, 0);
		send_frame(0, 12);
		wait_done(0);
		check_count(0, 12);
		check_stored(0, 0, 12);
	endtask

	task automatic short_frame_tail();
		fill_payload(12, 6);
		arm_slot(1, 32);
		send_frame(12, 6);
		wait_done(1);
		check_count(1, 6);
		check_stored(32, 12, 6);
	endtask

	task automatic frame_waits_for_slot();
		fill_payload(18, 8);
		send_frame(18, 8);
		repeat (100) @(negedge sys_clk);
		check_eq("slot_done_o", 32'(slot_done), 32'h3);  // Only the two older flags.
		check_count(0, 12);
		arm_slot(0, 64);
		wait_done(0);
		check_count(0, 8);
		check_stored(64, 18, 8);
	endtask

	task automatic long_frame_truncate();
		fill_payload(26, 24);
		arm_slot(1, 60);
		send_frame(26, 24);
		wait_done(1);
		check_count(1, 24);
		check_stored(60, 26, 24);
		check_stored(64, 18, 8);  // Words past the MTU keep the previous frame.
	endtask

	task automatic alternating_slots();
		fill_payload(50, 10);
		fill_payload(60, 7);
		arm_slot(0, 96);
		arm_slot(1, 128);
		send_frame(50, 10);
		send_frame(60, 7);
		wait_done(0);
		wait_done(1);
		check_count(0, 10);
		check_count(1, 7);
		check_stored(96, 50, 10);
		check_stored(128, 60, 7);
	endtask

	// 63 bytes and the eof entry take all 64 FIFO entries while no slot is armed.
	task automatic fifo_fill_drain();
		fill_payload(67, 63);
		send_frame(67, 63);
		check_eq("fifo_full_o", 32'(fifo_full), 32'h1);
		arm_slot(0, 160);
		wait_done(0);
		check_eq("fifo_full_o", 32'(fifo_full), 32'h0);
		check_count(0, 63);
		check_stored(160, 67, 63);
	endtask

	initial begin
		seed = 24;
		sys_rst = 1'b1;
		rx_rst = 1'b0;
		phy_rx_data = 4'h0;
		phy_dv = 1'b0;
		phy_rx_er = 1'b0;
		slot_wr = 1'b0;
		slot_sel = '0;
		slot_adr = '0;
		dbg_adr = '0;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		repeat (20) @(negedge sys_clk);  // FIFO reset still has to reach the PHY side.
		single_frame_store();
		short_frame_tail();
		frame_waits_for_slot();
		long_frame_truncate();
		alternating_slots();
		fifo_fill_drain();
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* design/minimac_rx_top.sv */
`timescale 1ns/1ps

module minimac_rx_top #(
	parameter logic [minimac_pkg::CNT_W-1:0] MTU = minimac_pkg::MTU_DEFAULT
) (
	input  logic                               sys_clk,
	input  logic                               sys_rst,
	input  logic                               rx_rst_i,
	input  logic                               phy_rx_clk_i,
	input  logic [3:0]                         phy_rx_data_i,
	input  logic                               phy_dv_i,
	input  logic                               phy_rx_er_i,
	output logic                               fifo_full_o,
	input  logic                               slot_wr_i,
	input  logic [minimac_pkg::SLOT_SEL_W-1:0] slot_sel_i,
	input  logic [minimac_pkg::ADR_W-1:0]      slot_adr_i,
	output logic [minimac_pkg::SLOT_COUNT-1:0] slot_done_o,
	output logic [minimac_pkg::CNT_W-1:0]      slot_count_o,
	input  logic [minimac_pkg::MEM_AW-1:0]     dbg_adr_i,
	output logic [minimac_pkg::WORD_W-1:0]     dbg_dat_o
);
	import minimac_pkg::*;

	logic fifo_rst;
	logic fifo_empty;
	logic fifo_ack;
	logic fifo_eof;
	logic [7:0] fifo_data;
	logic rx_valid;
	logic [ADR_W-1:0] rx_adr;
	logic rx_incrcount;
	logic rx_endframe;

	minimac_wb_if wb_bus ();

	assign fifo_rst = sys_rst | rx_rst_i;  // Either reset empties the FIFO.

	minimac_rxfifo rxfifo (
		.sys_clk      (sys_clk),
		.rx_rst_i     (fifo_rst),
		.phy_rx_clk_i (phy_rx_clk_i),
		.phy_rx_data_i(phy_rx_data_i),
		.phy_dv_i     (phy_dv_i),
		.phy_rx_er_i  (phy_rx_er_i),
		.empty_o      (fifo_empty),
		.ack_i        (fifo_ack),
		.eof_o        (fifo_eof),
		.data_o       (fifo_data),
		.fifo_full_o  (fifo_full_o)
	);

	minimac_rx #(
		.MTU(MTU)
	) rx (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.rx_rst_i      (rx_rst_i),
		.wb            (wb_bus.master),
		.rx_valid_i    (rx_valid),
		.rx_adr_i      (rx_adr),
		.rx_incrcount_o(rx_incrcount),
		.rx_endframe_o (rx_endframe),
		.fifo_empty_i  (fifo_empty),
		.fifo_ack_o    (fifo_ack),
		.fifo_eof_i    (fifo_eof),
		.fifo_data_i   (fifo_data)
	);

	minimac_slots slots (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.slot_wr_i     (slot_wr_i),
		.slot_sel_i    (slot_sel_i),
		.slot_adr_i    (slot_adr_i),
		.rx_valid_o    (rx_valid),
		.rx_adr_o      (rx_adr),
		.rx_incrcount_i(rx_incrcount),
		.rx_endframe_i (rx_endframe),
		.slot_done_o   (slot_done_o),
		.slot_count_o  (slot_count_o)
	);

	minimac_rxmem rxmem (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.wb       (wb_bus.slave),
		.dbg_adr_i(dbg_adr_i),
		.dbg_dat_o(dbg_dat_o)
	);

endmodule

/* design/minimac_rxmem.sv */
`timescale 1ns/1ps

module minimac_rxmem (
	input  logic                           sys_clk,
	input  logic                           sys_rst,
	minimac_wb_if.slave                    wb,
	input  logic [minimac_pkg::MEM_AW-1:0] dbg_adr_i,
	output logic [minimac_pkg::WORD_W-1:0] dbg_dat_o
);
	import minimac_pkg::*;

	logic [WORD_W-1:0] mem [0:2**MEM_AW-1];
	logic ack_q;
	logic wr_en;

	// The write lands on the edge that sees the ack.
	assign wr_en = wb.cyc & wb.stb & ack_q;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			ack_q <= 1'b0;
		else
			ack_q <= wb.cyc & wb.stb & ~ack_q;  // Single-cycle pulse per access.
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en)
			mem[wb.adr[MEM_AW-1:0]] <= wb.dat;  // Upper address bits are ignored.
	end

	assign wb.ack = ack_q;
	assign dbg_dat_o = mem[dbg_adr_i];

endmodule

/* design/minimac_slots.sv */
`timescale 1ns/1ps

module minimac_slots (
	input  logic                               sys_clk,
	input  logic                               sys_rst,
	input  logic                               slot_wr_i,
	input  logic [minimac_pkg::SLOT_SEL_W-1:0] slot_sel_i,
	input  logic [minimac_pkg::ADR_W-1:0]      slot_adr_i,
	output logic                               rx_valid_o,
	output logic [minimac_pkg::ADR_W-1:0]      rx_adr_o,
	input  logic                               rx_incrcount_i,
	input  logic                               rx_endframe_i,
	output logic [minimac_pkg::SLOT_COUNT-1:0] slot_done_o,
	output logic [minimac_pkg::CNT_W-1:0]      slot_count_o
);
	import minimac_pkg::*;

	logic [ADR_W-1:0] base_q [SLOT_COUNT];
	logic [CNT_W-1:0] count_q [SLOT_COUNT];
	logic [SLOT_COUNT-1:0] armed_q;
	logic [SLOT_SEL_W-1:0] cur_q;
	logic [SLOT_SEL_W-1:0] cur_next;

	// Slots are used in turn.
	assign cur_next = (cur_q == SLOT_SEL_W'(SLOT_COUNT - 1)) ? '0 : cur_q + 1'b1;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			armed_q <= '0;
			slot_done_o <= '0;
			cur_q <= '0;
			for (int i = 0; i < SLOT_COUNT; i++)
				count_q[i] <= '0;
		end else begin
			if (rx_incrcount_i)
				count_q[cur_q] <= count_q[cur_q] + 1'b1;
			if (rx_endframe_i) begin
				armed_q[cur_q] <= 1'b0;
				slot_done_o[cur_q] <= 1'b1;
				cur_q <= cur_next;
			end
			if (slot_wr_i) begin
				armed_q[slot_sel_i] <= 1'b1;  // Host hands the slot back.
				slot_done_o[slot_sel_i] <= 1'b0;
				count_q[slot_sel_i] <= '0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (slot_wr_i)
			base_q[slot_sel_i] <= slot_adr_i;
	end

	assign rx_valid_o = armed_q[cur_q] & ~slot_done_o[cur_q];
	assign rx_adr_o = base_q[cur_q];
	assign slot_count_o = count_q[slot_sel_i];

endmodule

/* design/minimac_rx.sv */
`timescale 1ns/1ps

module minimac_rx #(
	parameter logic [minimac_pkg::CNT_W-1:0] MTU = minimac_pkg::MTU_DEFAULT
) (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  logic                          rx_rst_i,
	minimac_wb_if.master                  wb,
	input  logic                          rx_valid_i,
	input  logic [minimac_pkg::ADR_W-1:0] rx_adr_i,
	output logic                          rx_incrcount_o,
	output logic                          rx_endframe_o,
	input  logic                          fifo_empty_i,
	output logic                          fifo_ack_o,
	input  logic                          fifo_eof_i,
	input  logic [7:0]                    fifo_data_i
);
	import minimac_pkg::*;

	logic frame_rst;
	logic [1:0] state_q;
	logic [1:0] state_d;

	logic in_frame_q;
	logic start_of_frame;
	logic end_of_frame;

	logic loadbyte_en;
	logic [1:0] byte_cnt_q;
	logic full_word;
	logic empty_word;

	logic [CNT_W-1:0] maxcount_q;
	logic still_place_q;

	logic next_wb_adr;
	logic bus_stb;
	logic [ADR_W-1:0] adr_q;
	logic [WORD_W-1:0] dat_q;

	assign frame_rst = sys_rst | rx_rst_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame tracking and byte packing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (frame_rst)
			in_frame_q <= 1'b0;
		else if (end_of_frame)
			in_frame_q <= 1'b0;
		else if (start_of_frame)
			in_frame_q <= 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (frame_rst)
			byte_cnt_q <= '0;
		else if (start_of_frame)
			byte_cnt_q <= '0;  // Every frame starts on a word boundary.
		else if (loadbyte_en)
			byte_cnt_q <= byte_cnt_q + 2'd1;
	end

	// First byte of the word lands in the top lane.
	always_ff @(posedge sys_clk) begin
		if (loadbyte_en)
			dat_q[WORD_W-1-8*byte_cnt_q -: 8] <= fifo_data_i;
	end

	assign full_word = &byte_cnt_q;
	assign empty_word = (byte_cnt_q == 2'd0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// MTU limit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (frame_rst) begin
			maxcount_q <= MTU;
			still_place_q <= 1'b0;
		end else begin
			if (start_of_frame)
				maxcount_q <= MTU;
			else if (loadbyte_en && maxcount_q != '0)
				maxcount_q <= maxcount_q - 1'b1;  // Stops at zero.
			if (loadbyte_en)
				still_place_q <= (maxcount_q != '0);  // Held for the whole strobe.
		end
	end

	assign rx_incrcount_o = loadbyte_en;  // Bytes past the MTU are still counted.

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			adr_q <= '0;
		else if (start_of_frame)
			adr_q <= rx_adr_i;
		else if (next_wb_adr)
			adr_q <= adr_q + 1'b1;
	end

	assign wb.adr = adr_q;
	assign wb.dat = dat_q;
	assign wb.cyc = bus_stb;
	assign wb.stb = bus_stb;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (frame_rst)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		fifo_ack_o = 1'b0;
		rx_endframe_o = 1'b0;
		start_of_frame = 1'b0;
		end_of_frame = 1'b0;
		loadbyte_en = 1'b0;
		bus_stb = 1'b0;
		next_wb_adr = 1'b0;

		case (state_q)
			ST_IDLE: begin
				if (~fifo_empty_i & rx_valid_i) begin  // No slot means bytes wait.
					if (fifo_eof_i) begin
						fifo_ack_o = 1'b1;  // A stray eof is dropped here.
						if (in_frame_q) begin
							end_of_frame = 1'b1;
							if (empty_word)
								rx_endframe_o = 1'b1;
							else
								state_d = ST_SENDLAST;
						end
					end else begin
						start_of_frame = ~in_frame_q;
						state_d = ST_LOADBYTE;
					end
				end
			end
			ST_LOADBYTE: begin
				loadbyte_en = 1'b1;
				fifo_ack_o = 1'b1;
				state_d = full_word ? ST_WBSTROBE : ST_IDLE;
			end
			ST_WBSTROBE: begin
				bus_stb = still_place_q;
				if (wb.ack | ~still_place_q) begin
					next_wb_adr = 1'b1;  // Skipped words still advance the address.
					state_d = ST_IDLE;
				end
			end
			ST_SENDLAST: begin
				bus_stb = still_place_q;
				if (wb.ack | ~still_place_q) begin
					rx_endframe_o = 1'b1;
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

endmodule

/* design/minimac_rxfifo.sv */
`timescale 1ns/1ps

module minimac_rxfifo (
	input  logic       sys_clk,
	input  logic       rx_rst_i,
	input  logic       phy_rx_clk_i,
	input  logic [3:0] phy_rx_data_i,
	input  logic       phy_dv_i,
	input  logic       phy_rx_er_i,
	output logic       empty_o,
	input  logic       ack_i,
	output logic       eof_o,
	output logic [7:0] data_o,
	output logic       fifo_full_o
);
	import minimac_pkg::*;

	logic [ENTRY_W-1:0] fifo_mem [0:2**FIFO_AW-1];

	logic [2:0] rst_stretch_q;
	logic rst_hold_q;
	logic rd_rst;
	logic [1:0] phy_rst_sync;
	logic phy_rst;

	logic dv_q;
	logic half_q;
	logic [3:0] lo_nibble_q;
	logic wr_req;
	logic wr_en;
	logic [ENTRY_W-1:0] wr_entry;
	logic [FIFO_AW:0] wr_bin_q;
	logic [FIFO_AW:0] wr_bin_next;
	logic [FIFO_AW:0] wr_gray_q;
	logic [FIFO_AW:0] rd_gray_meta;
	logic [FIFO_AW:0] rd_gray_sync;
	logic [FIFO_AW:0] rd_gray_full;

	logic [FIFO_AW:0] rd_bin_q;
	logic [FIFO_AW:0] rd_bin_next;
	logic [FIFO_AW:0] rd_gray_q;
	logic [FIFO_AW:0] wr_gray_meta;
	logic [FIFO_AW:0] wr_gray_sync;
	logic [ENTRY_W-1:0] head;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reset distribution
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// The PHY clock is slower than sys_clk, so a short reset pulse is
	// stretched before it crosses over.
	always_ff @(posedge sys_clk) begin
		if (rx_rst_i)
			rst_stretch_q <= '1;
		else if (rst_stretch_q != '0)
			rst_stretch_q <= rst_stretch_q - 1'b1;
		rst_hold_q <= rx_rst_i | (rst_stretch_q != '0);
	end
	assign rd_rst = rx_rst_i | rst_hold_q;

	always_ff @(posedge phy_rx_clk_i) begin
		phy_rst_sync <= {phy_rst_sync[0], rst_hold_q};
	end
	assign phy_rst = phy_rst_sync[1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PHY clock domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge phy_rx_clk_i) begin
		if (phy_rst) begin
			dv_q <= 1'b0;
			half_q <= 1'b0;
		end else begin
			dv_q <= phy_dv_i;
			half_q <= phy_dv_i & ~half_q;  // An odd nibble at the end is dropped.
		end
	end

	always_ff @(posedge phy_rx_clk_i) begin
		if (phy_dv_i & ~half_q)
			lo_nibble_q <= phy_rx_data_i;  // Low nibble arrives first.
	end

	// Receive errors on phy_rx_er_i are not acted upon.
	always_comb begin
		wr_req = 1'b0;
		wr_entry = {1'b0, phy_rx_data_i, lo_nibble_q};
		if (phy_dv_i & half_q) begin
			wr_req = 1'b1;
		end else if (~phy_dv_i & dv_q) begin
			wr_req = 1'b1;
			wr_entry = EOF_ENTRY;  // Falling edge of dv closes the frame.
		end
	end

	// Full when the write pointer is one lap ahead of the read pointer.
	assign rd_gray_full = {~rd_gray_sync[FIFO_AW:FIFO_AW-1], rd_gray_sync[FIFO_AW-2:0]};
	assign fifo_full_o = (wr_gray_q == rd_gray_full);
	assign wr_en = wr_req & ~fifo_full_o & ~phy_rst;  // Entries are lost while full.
	assign wr_bin_next = wr_bin_q + 1'b1;

	always_ff @(posedge phy_rx_clk_i) begin
		if (phy_rst) begin
			wr_bin_q <= '0;
			wr_gray_q <= '0;
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
		end else begin
			if (wr_en) begin
				wr_bin_q <= wr_bin_next;
				wr_gray_q <= wr_bin_next ^ (wr_bin_next >> 1);
			end
			rd_gray_meta <= rd_gray_q;
			rd_gray_sync <= rd_gray_meta;
		end
	end

	always_ff @(posedge phy_rx_clk_i) begin
		if (wr_en)
			fifo_mem[wr_bin_q[FIFO_AW-1:0]] <= wr_entry;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// System clock domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign empty_o = (rd_gray_q == wr_gray_sync);
	assign rd_bin_next = rd_bin_q + 1'b1;

	always_ff @(posedge sys_clk) begin
		if (rd_rst) begin
			rd_bin_q <= '0;
			rd_gray_q <= '0;
			wr_gray_meta <= '0;
			wr_gray_sync <= '0;
		end else begin
			if (ack_i & ~empty_o) begin
				rd_bin_q <= rd_bin_next;
				rd_gray_q <= rd_bin_next ^ (rd_bin_next >> 1);
			end
			wr_gray_meta <= wr_gray_q;
			wr_gray_sync <= wr_gray_meta;
		end
	end

	assign head = fifo_mem[rd_bin_q[FIFO_AW-1:0]];
	assign eof_o = head[8];
	assign data_o = head[7:0];

endmodule

/* design/minimac_wb_if.sv */
`timescale 1ns/1ps

interface minimac_wb_if;
	import minimac_pkg::*;

	logic [ADR_W-1:0] adr;   // Word address.
	logic [WORD_W-1:0] dat;  // Write data.
	logic cyc;
	logic stb;
	logic ack;

	modport master (
		output adr,
		output dat,
		output cyc,
		output stb,
		input  ack
	);

	modport slave (
		input  adr,
		input  dat,
		input  cyc,
		input  stb,
		output ack
	);

endinterface

/* design/minimac_pkg.sv */
package minimac_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and memory geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int WORD_W = 32;  // Bus data word.
	localparam int ADR_W = 30;   // Word address from byte address bits 31:2.
	localparam int MEM_AW = 8;   // 256 words of receive memory.
	localparam int FIFO_AW = 6;  // 64 entries in the receive FIFO.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame accounting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int CNT_W = 11;
	localparam logic [CNT_W-1:0] MTU_DEFAULT = 11'd2000;
	localparam int SLOT_COUNT = 2;
	localparam int SLOT_SEL_W = $clog2(SLOT_COUNT);

	// Receive engine states.
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_LOADBYTE = 2'd1;
	localparam logic [1:0] ST_WBSTROBE = 2'd2;
	localparam logic [1:0] ST_SENDLAST = 2'd3;

	// FIFO entry with the end-of-frame flag on top of the byte.
	localparam int ENTRY_W = 9;
	localparam logic [ENTRY_W-1:0] EOF_ENTRY = 9'h100;

endpackage
